// File: hdl/cpu_isa_pkg.sv
package cpu_isa_pkg;

    // field widths of the instruction word
    localparam int WORD_W   = 32;
    localparam int OPCODE_W = 6;
    localparam int FUNC_W   = 6;
    localparam int REG_ID_W = 5;
    localparam int SHAMT_W  = 5;
    localparam int IMM_W    = 16;
    localparam int JADDR_W  = 26;

    typedef logic [WORD_W-1:0]   word_t;
    typedef logic [REG_ID_W-1:0] reg_id_t;
    typedef logic [SHAMT_W-1:0]  shamt_t;
    typedef logic [JADDR_W-1:0]  jaddr_t;

    // primary opcodes, MIPS encoding
    typedef enum logic [OPCODE_W-1:0] {
        OP_RTYPE = 6'h00,
        OP_J     = 6'h02,
        OP_BEQ   = 6'h04,
        OP_ADDIU = 6'h09,
        OP_ORI   = 6'h0d,
        OP_LUI   = 6'h0f,
        OP_LW    = 6'h23,
        OP_SW    = 6'h2b
    } opcode_e;

    // function field of R-type instructions
    typedef enum logic [FUNC_W-1:0] {
        FN_SLL  = 6'h00,
        FN_JR   = 6'h08,
        FN_ADDU = 6'h21,
        FN_SUBU = 6'h23,
        FN_AND  = 6'h24,
        FN_OR   = 6'h25,
        FN_SLT  = 6'h2a
    } func_e;

    typedef enum logic [2:0] {
        ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_SLT, ALU_SLL, ALU_LUI
    } alu_op_e;

endpackage

// File: hdl/cpu_bus_pkg.sv
package cpu_bus_pkg;

    // decoded control for one instruction
    typedef struct packed {
        cpu_isa_pkg::alu_op_e alu_op;
        logic                 alu_src;    // second operand is the immediate
        logic                 reg_write;
        logic                 reg_dst;    // write rd, else rt
        logic                 mem_read;
        logic                 mem_write;
        logic                 is_branch;
        logic                 is_jump;
        logic                 is_jr;
    } ctrl_t;

    // data memory request, held stable while req is high
    typedef struct packed {
        logic               write;
        cpu_isa_pkg::word_t addr;
        cpu_isa_pkg::word_t wdata;
    } dmem_req_t;

    // one record per completed instruction
    typedef struct packed {
        cpu_isa_pkg::word_t   pc;
        logic                 reg_write;
        cpu_isa_pkg::reg_id_t rd;
        cpu_isa_pkg::word_t   wdata;
        logic                 taken;
    } retire_t;

endpackage

// File: hdl/ifetch.sv
`timescale 1ns/1ps

module ifetch #(
    parameter cpu_isa_pkg::word_t RESET_PC = '0
) (
    input  logic               sys_clk,
    input  logic               rst_n,
    input  logic               stall,
    input  logic               do_jump,
    input  cpu_isa_pkg::word_t jump_addr,
    output cpu_isa_pkg::word_t pc,
    output cpu_isa_pkg::word_t next_pc
);
    import cpu_isa_pkg::*;

    word_t pc_sel;

    // sequential successor, also used for branch and jump targets
    assign next_pc = pc + 32'd4;

    // control transfer wins over the sequential path
    assign pc_sel = do_jump ? jump_addr : next_pc;

    always_ff @(posedge sys_clk) begin
        if (!rst_n) begin
            pc <= RESET_PC;
        end else if (!stall) begin
            pc <= pc_sel;
        end
    end

    // a jr to a misaligned register value would show up here
    pc_aligned: assert property (
        @(posedge sys_clk) disable iff (!rst_n)
        pc[1:0] == 2'b00
    ) else $error("ifetch: misaligned pc %h", pc);

endmodule

// File: hdl/idecoder.sv
`timescale 1ns/1ps

module idecoder (
    input  logic                 sys_clk,
    input  logic                 rst_n,
    input  cpu_isa_pkg::word_t   ins,
    input  logic                 reg_write,
    input  cpu_isa_pkg::reg_id_t reg_write_id,
    input  cpu_isa_pkg::word_t   reg_write_data,
    output cpu_bus_pkg::ctrl_t   ctrl,
    output cpu_isa_pkg::word_t   ext_immd,
    output cpu_isa_pkg::shamt_t  shift_amt,
    output cpu_isa_pkg::jaddr_t  j_addr,
    output cpu_isa_pkg::reg_id_t rs_id,
    output cpu_isa_pkg::reg_id_t rt_id,
    output cpu_isa_pkg::reg_id_t rd_id,
    output cpu_isa_pkg::word_t   reg_read1,
    output cpu_isa_pkg::word_t   reg_read2
);
    import cpu_isa_pkg::*;

    opcode_e          opcode;
    func_e            func;
    logic [IMM_W-1:0] immd;
    word_t            regs [32];

    // instruction fields
    assign opcode    = opcode_e'(ins[31:26]);
    assign rs_id     = ins[25:21];
    assign rt_id     = ins[20:16];
    assign rd_id     = ins[15:11];
    assign shift_amt = ins[10:6];
    assign func      = func_e'(ins[5:0]);
    assign immd      = ins[IMM_W-1:0];
    assign j_addr    = ins[JADDR_W-1:0];

    // ori is the only zero-extended immediate here
    assign ext_immd = (opcode == OP_ORI) ? {{(WORD_W-IMM_W){1'b0}}, immd}
                                         : {{(WORD_W-IMM_W){immd[IMM_W-1]}}, immd};

    always_comb begin
        ctrl = '0;
        case (opcode)
            OP_RTYPE: begin
                ctrl.reg_write = 1'b1;
                ctrl.reg_dst   = 1'b1;
                case (func)
                    FN_SLL:  ctrl.alu_op = ALU_SLL;
                    FN_ADDU: ctrl.alu_op = ALU_ADD;
                    FN_SUBU: ctrl.alu_op = ALU_SUB;
                    FN_AND:  ctrl.alu_op = ALU_AND;
                    FN_OR:   ctrl.alu_op = ALU_OR;
                    FN_SLT:  ctrl.alu_op = ALU_SLT;
                    FN_JR: begin
                        ctrl.reg_write = 1'b0;
                        ctrl.is_jr     = 1'b1;
                    end
                    // unsupported function, no-op
                    default: ctrl = '0;
                endcase
            end
            OP_ADDIU, OP_ORI, OP_LUI, OP_LW: begin
                ctrl.alu_src   = 1'b1;
                ctrl.reg_write = 1'b1;
                ctrl.mem_read  = (opcode == OP_LW);
                ctrl.alu_op    = (opcode == OP_ORI) ? ALU_OR :
                                 (opcode == OP_LUI) ? ALU_LUI : ALU_ADD;
            end
            OP_SW: begin
                ctrl.alu_src   = 1'b1;
                ctrl.mem_write = 1'b1;
            end
            OP_BEQ: begin
                ctrl.is_branch = 1'b1;
                ctrl.alu_op    = ALU_SUB;
            end
            OP_J:    ctrl.is_jump = 1'b1;
            default: ctrl = '0;
        endcase
    end

    // register file, r0 reads as zero
    assign reg_read1 = (rs_id == '0) ? '0 : regs[rs_id];
    assign reg_read2 = (rt_id == '0) ? '0 : regs[rt_id];

    always_ff @(posedge sys_clk) begin
        if (!rst_n) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (reg_write && reg_write_id != '0) begin
            regs[reg_write_id] <= reg_write_data;
        end
    end

endmodule

// File: hdl/execute.sv
`timescale 1ns/1ps

module execute (
    input  cpu_bus_pkg::ctrl_t  ctrl,
    input  cpu_isa_pkg::word_t  reg1,
    input  cpu_isa_pkg::word_t  reg2,
    input  cpu_isa_pkg::word_t  immd,
    input  cpu_isa_pkg::word_t  next_pc,
    input  cpu_isa_pkg::shamt_t shift_amt,
    input  cpu_isa_pkg::jaddr_t j_addr,
    output cpu_isa_pkg::word_t  result,
    output logic                do_jump,
    output cpu_isa_pkg::word_t  jump_addr
);
    import cpu_isa_pkg::*;

    word_t op_b;
    word_t br_target;
    word_t j_target;
    logic  taken;

    assign op_b = ctrl.alu_src ? immd : reg2;

    always_comb begin
        case (ctrl.alu_op)
            ALU_ADD: result = reg1 + op_b;
            ALU_SUB: result = reg1 - op_b;
            ALU_AND: result = reg1 & op_b;
            ALU_OR:  result = reg1 | op_b;
            ALU_SLT: result = {{(WORD_W-1){1'b0}}, $signed(reg1) < $signed(op_b)};
            // sll shifts rt, rs is ignored
            ALU_SLL: result = reg2 << shift_amt;
            ALU_LUI: result = {op_b[IMM_W-1:0], {IMM_W{1'b0}}};
            default: result = reg1 + op_b;
        endcase
    end

    // beq compares the raw register values
    assign taken = ctrl.is_branch && (reg1 == reg2);

    assign br_target = next_pc + {immd[WORD_W-3:0], 2'b00};
    assign j_target  = {next_pc[WORD_W-1:WORD_W-4], j_addr, 2'b00};

    assign do_jump = taken || ctrl.is_jump || ctrl.is_jr;

    always_comb begin
        if (ctrl.is_jr) begin
            jump_addr = reg1;
        end else if (ctrl.is_jump) begin
            jump_addr = j_target;
        end else begin
            jump_addr = br_target;
        end
    end

    // decoder must flag at most one transfer kind
    transfer_decoded: assert final (
        $onehot0({ctrl.is_branch, ctrl.is_jump, ctrl.is_jr})
    ) else $error("execute: more than one transfer kind decoded");

endmodule

// File: hdl/mmu.sv
`timescale 1ns/1ps

module mmu (
    input  logic                    sys_clk,
    input  logic                    rst_n,
    input  logic                    mem_read,
    input  logic                    mem_write,
    input  cpu_isa_pkg::word_t      mem_addr,
    input  cpu_isa_pkg::word_t      mem_wd,
    input  logic                    dmem_ack,
    input  cpu_isa_pkg::word_t      dmem_rdata,
    output logic                    dmem_req_valid,
    output cpu_bus_pkg::dmem_req_t  dmem_req,
    output logic                    stall,
    output cpu_isa_pkg::word_t      load_data
);
    typedef enum logic [1:0] {IDLE, REQ, RELEASE, DONE} state_e;

    state_e state;
    state_e state_next;
    logic   mem_op;

    assign mem_op = mem_read || mem_write;

    always_comb begin
        state_next = state;
        case (state)
            IDLE:    if (mem_op) state_next = REQ;
            REQ:     if (dmem_ack) state_next = RELEASE;
            // wait for the memory to drop ack
            RELEASE: if (!dmem_ack) state_next = DONE;
            DONE:    state_next = IDLE;
            default: state_next = IDLE;
        endcase
    end

    always_ff @(posedge sys_clk) begin
        if (!rst_n) begin
            state <= IDLE;
        end else begin
            state <= state_next;
        end
    end

    always_ff @(posedge sys_clk) begin
        if (state == IDLE && mem_op) begin
            dmem_req <= '{write: mem_write, addr: mem_addr, wdata: mem_wd};
        end
        // rdata is only valid on the first ack cycle
        if (state == REQ && dmem_ack && !dmem_req.write) begin
            load_data <= dmem_rdata;
        end
    end

    assign dmem_req_valid = (state == REQ);

    // DONE is the completing cycle, so stall is already low there
    assign stall = (state == IDLE && mem_op) || state == REQ || state == RELEASE;

    no_req_during_ack: assert property (
        @(posedge sys_clk) disable iff (!rst_n)
        (dmem_ack && !dmem_req_valid) |=> !dmem_req_valid
    ) else $error("mmu: req raised while ack still high");

    // the stalled instruction still computes the latched request
    req_stable: assert property (
        @(posedge sys_clk) disable iff (!rst_n)
        dmem_req_valid |-> (dmem_req.write == mem_write && dmem_req.addr == mem_addr &&
                            dmem_req.wdata == mem_wd)
    ) else $error("mmu: request no longer matches the stalled instruction");

endmodule

// File: hdl/top.sv
`timescale 1ns/1ps

module top #(
    parameter cpu_isa_pkg::word_t RESET_PC = '0
) (
    input  logic                   sys_clk,
    input  logic                   rst_n,
    input  cpu_isa_pkg::word_t     imem_data,
    input  logic                   dmem_ack,
    input  cpu_isa_pkg::word_t     dmem_rdata,
    output cpu_isa_pkg::word_t     imem_addr,
    output logic                   dmem_req_valid,
    output cpu_bus_pkg::dmem_req_t dmem_req,
    output logic                   retire_valid,
    output cpu_bus_pkg::retire_t   retire
);
    import cpu_isa_pkg::*;
    import cpu_bus_pkg::*;

    word_t   f_pc;
    word_t   f_next_pc;
    ctrl_t   d_ctrl;
    word_t   d_ext_immd;
    shamt_t  d_shift_amt;
    jaddr_t  d_j_addr;
    reg_id_t d_rt_id;
    reg_id_t d_rd_id;
    word_t   d_reg_read1;
    word_t   d_reg_read2;
    word_t   e_result;
    logic    e_do_jump;
    word_t   e_jump_addr;
    word_t   m_load_data;
    logic    m_stall;
    logic    wb_reg_write;
    reg_id_t wb_reg_write_id;
    word_t   wb_data;

    assign imem_addr = f_pc;

    // write back, held off until the memory access completes
    assign wb_reg_write    = d_ctrl.reg_write && !m_stall;
    assign wb_reg_write_id = d_ctrl.reg_dst ? d_rd_id : d_rt_id;
    assign wb_data         = d_ctrl.mem_read ? m_load_data : e_result;

    ifetch #(.RESET_PC(RESET_PC)) fetch (
        .sys_clk(sys_clk), .rst_n(rst_n), .stall(m_stall),
        .do_jump(e_do_jump), .jump_addr(e_jump_addr),
        .pc(f_pc), .next_pc(f_next_pc)
    );

    idecoder decoder (
        .sys_clk(sys_clk), .rst_n(rst_n), .ins(imem_data),
        .reg_write(wb_reg_write), .reg_write_id(wb_reg_write_id),
        .reg_write_data(wb_data),
        .ctrl(d_ctrl), .ext_immd(d_ext_immd), .shift_amt(d_shift_amt),
        .j_addr(d_j_addr), .rs_id(), .rt_id(d_rt_id), .rd_id(d_rd_id),
        .reg_read1(d_reg_read1), .reg_read2(d_reg_read2)
    );

    execute ex (
        .ctrl(d_ctrl), .reg1(d_reg_read1), .reg2(d_reg_read2),
        .immd(d_ext_immd), .next_pc(f_next_pc), .shift_amt(d_shift_amt),
        .j_addr(d_j_addr), .result(e_result), .do_jump(e_do_jump),
        .jump_addr(e_jump_addr)
    );

    mmu mmud (
        .sys_clk(sys_clk), .rst_n(rst_n),
        .mem_read(d_ctrl.mem_read), .mem_write(d_ctrl.mem_write),
        .mem_addr(e_result), .mem_wd(d_reg_read2),
        .dmem_ack(dmem_ack), .dmem_rdata(dmem_rdata),
        .dmem_req_valid(dmem_req_valid), .dmem_req(dmem_req),
        .stall(m_stall), .load_data(m_load_data)
    );

    // record shows up on the edge that commits the instruction
    always_ff @(posedge sys_clk) begin
        if (!rst_n) begin
            retire_valid <= 1'b0;
        end else begin
            retire_valid <= !m_stall;
        end
    end

    always_ff @(posedge sys_clk) begin
        if (!m_stall) begin
            retire <= '{pc: f_pc, reg_write: d_ctrl.reg_write, rd: wb_reg_write_id,
                        wdata: wb_data, taken: e_do_jump};
        end
    end

endmodule

// File: tests/tb_top.sv
`timescale 1ns/1ps

module tb_top;
    import cpu_isa_pkg::*;
    import cpu_bus_pkg::*;

    localparam word_t RESET_PC   = 32'h0000_0400;
    localparam int    IMEM_WORDS = 256;
    localparam int    DMEM_WORDS = 64;

    logic      sys_clk;
    logic      rst_n;
    word_t     imem_data;
    logic      dmem_ack;
    word_t     dmem_rdata;
    word_t     imem_addr;
    logic      dmem_req_valid;
    dmem_req_t dmem_req;
    logic      retire_valid;
    retire_t   retire;

    word_t     prog [IMEM_WORDS];
    word_t     data_mem [DMEM_WORDS];
    word_t     asm_pc;
    // architectural reference state
    word_t     ref_pc;
    word_t     ref_regs [32];
    word_t     ref_mem [DMEM_WORDS];
    string     test_names [8];
    word_t     test_ends [8];
    int        num_tests = 0;
    int        cur_test = 0;
    int        test_errors = 0;
    int        pass_count = 0;
    int        fail_count = 0;
    logic      dmem_busy = 1'b0;
    dmem_req_t req_queue [$];

    top #(.RESET_PC(RESET_PC)) top_inst (
        .sys_clk(sys_clk), .rst_n(rst_n), .imem_data(imem_data),
        .dmem_ack(dmem_ack), .dmem_rdata(dmem_rdata), .imem_addr(imem_addr),
        .dmem_req_valid(dmem_req_valid), .dmem_req(dmem_req),
        .retire_valid(retire_valid), .retire(retire)
    );

    initial sys_clk = 1'b0;
    always #10 sys_clk = ~sys_clk;

    function automatic word_t fetch_word(word_t addr);
        word_t off;
        off = (addr - RESET_PC) >> 2;
        return (off < IMEM_WORDS) ? prog[off] : '0;
    endfunction

    // instruction port answers in the same cycle
    assign imem_data = fetch_word(imem_addr);

    function automatic word_t fill_word(int idx);
        word_t a;
        a = idx * 4;
        return {~a[15:0], a[15:0]};
    endfunction

    function automatic word_t enc_r(func_e fn, reg_id_t rd, reg_id_t rs, reg_id_t rt,
                                    shamt_t sh);
        return {OP_RTYPE, rs, rt, rd, sh, fn};
    endfunction

    function automatic word_t enc_i(opcode_e op, reg_id_t rt, reg_id_t rs, logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    function automatic word_t enc_j(word_t target);
        return {OP_J, target[27:2]};
    endfunction

    task automatic emit(word_t w);
        prog[(asm_pc - RESET_PC) >> 2] = w;
        asm_pc = asm_pc + 32'd4;
    endtask

    task automatic add_section(string name);
        test_names[num_tests] = name;
        test_ends[num_tests] = asm_pc;
        num_tests++;
    endtask

    // steps the ISA model by one instruction
    function automatic retire_t ref_step(output logic mem_op, output dmem_req_t mem_req);
        word_t   ins;
        opcode_e op;
        reg_id_t rs;
        reg_id_t rt;
        word_t   a;
        word_t   b;
        word_t   sext;
        word_t   addr;
        word_t   pc4;
        word_t   nxt;
        word_t   val;
        retire_t r;
        ins = fetch_word(ref_pc);
        op = opcode_e'(ins[31:26]);
        rs = ins[25:21];
        rt = ins[20:16];
        a = ref_regs[rs];
        b = ref_regs[rt];
        sext = {{16{ins[15]}}, ins[15:0]};
        addr = a + sext;
        pc4 = ref_pc + 32'd4;
        nxt = pc4;
        val = '0;
        r = '0;
        r.pc = ref_pc;
        r.rd = rt;
        mem_op = 1'b0;
        mem_req = '0;
        case (op)
            OP_RTYPE: begin
                r.reg_write = 1'b1;
                r.rd = ins[15:11];
                case (func_e'(ins[5:0]))
                    FN_ADDU: val = a + b;
                    FN_SUBU: val = a - b;
                    FN_AND:  val = a & b;
                    FN_OR:   val = a | b;
                    FN_SLT:  val = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                    FN_SLL:  val = b << ins[10:6];
                    FN_JR: begin
                        r.reg_write = 1'b0;
                        r.taken = 1'b1;
                        nxt = a;
                    end
                    default: r.reg_write = 1'b0;
                endcase
            end
            OP_ADDIU: begin
                r.reg_write = 1'b1;
                val = a + sext;
            end
            OP_ORI: begin
                r.reg_write = 1'b1;
                val = a | {16'h0, ins[15:0]};
            end
            OP_LUI: begin
                r.reg_write = 1'b1;
                val = {ins[15:0], 16'h0};
            end
            OP_LW: begin
                r.reg_write = 1'b1;
                val = ref_mem[addr[7:2]];
                mem_op = 1'b1;
                mem_req = '{write: 1'b0, addr: addr, wdata: '0};
            end
            OP_SW: begin
                ref_mem[addr[7:2]] = b;
                mem_op = 1'b1;
                mem_req = '{write: 1'b1, addr: addr, wdata: b};
            end
            OP_BEQ: begin
                if (a == b) begin
                    r.taken = 1'b1;
                    nxt = pc4 + {sext[29:0], 2'b00};
                end
            end
            OP_J: begin
                r.taken = 1'b1;
                nxt = {pc4[31:28], ins[25:0], 2'b00};
            end
            default: r.reg_write = 1'b0;
        endcase
        r.wdata = val;
        if (r.reg_write && r.rd != '0) begin
            ref_regs[r.rd] = val;
        end
        ref_pc = nxt;
        return r;
    endfunction

    task automatic init_model();
        ref_pc = RESET_PC;
        for (int i = 0; i < 32; i++) begin
            ref_regs[i] = '0;
        end
        for (int i = 0; i < DMEM_WORDS; i++) begin
            ref_mem[i] = fill_word(i);
            data_mem[i] = fill_word(i);
        end
    endtask

    // dry run of the model, sizes the watchdog
    function automatic int count_steps(word_t end_pc);
        int        n;
        logic      m;
        dmem_req_t q;
        n = 0;
        while (ref_pc != end_pc && n < 4096) begin
            void'(ref_step(m, q));
            n++;
        end
        return n;
    endfunction

    task automatic build_program();
        word_t   v;
        word_t   b;
        reg_id_t d;
        reg_id_t s;
        reg_id_t t;
        asm_pc = RESET_PC;
        for (int i = 0; i < IMEM_WORDS; i++) begin
            prog[i] = '0;
        end
        for (int i = 1; i <= 8; i++) begin
            v = $urandom();
            emit(enc_i(OP_LUI, reg_id_t'(i), 5'd0, v[31:16]));
            emit(enc_i(OP_ORI, reg_id_t'(i), reg_id_t'(i), v[15:0]));
        end
        for (int i = 0; i < 24; i++) begin
            d = reg_id_t'($urandom_range(12, 1));
            s = reg_id_t'($urandom_range(12, 0));
            t = reg_id_t'($urandom_range(12, 0));
            v = $urandom();
            case ($urandom_range(8, 0))
                0: emit(enc_r(FN_ADDU, d, s, t, 5'd0));
                1: emit(enc_r(FN_SUBU, d, s, t, 5'd0));
                2: emit(enc_r(FN_AND, d, s, t, 5'd0));
                3: emit(enc_r(FN_OR, d, s, t, 5'd0));
                4: emit(enc_r(FN_SLT, d, s, t, 5'd0));
                5: emit(enc_r(FN_SLL, d, 5'd0, t, v[4:0]));
                6: emit(enc_i(OP_ADDIU, d, s, v[15:0]));
                7: emit(enc_i(OP_ORI, d, s, v[15:0]));
                default: emit(enc_i(OP_LUI, d, 5'd0, v[15:0]));
            endcase
        end
        // r0 as a destination, then read back
        emit(enc_r(FN_ADDU, 5'd0, 5'd1, 5'd2, 5'd0));
        emit(enc_i(OP_ORI, 5'd0, 5'd3, 16'h1234));
        emit(enc_r(FN_ADDU, 5'd9, 5'd0, 5'd4, 5'd0));
        emit(enc_r(FN_OR, 5'd10, 5'd0, 5'd0, 5'd0));
        add_section("alu_logic");
        emit(enc_i(OP_ORI, 5'd20, 5'd0, 16'h0040));
        for (int i = 0; i < 6; i++) begin
            emit(enc_i(OP_SW, reg_id_t'(i + 1), 5'd20, 16'(4 * i)));
        end
        emit(enc_i(OP_SW, 5'd7, 5'd20, 16'hfff8));
        emit(enc_i(OP_SW, 5'd8, 5'd20, 16'h007c));
        add_section("store");
        for (int i = 0; i < 6; i++) begin
            emit(enc_i(OP_LW, reg_id_t'(13 + i), 5'd20, 16'(4 * i)));
        end
        emit(enc_i(OP_LW, 5'd19, 5'd0, 16'h0080));
        emit(enc_i(OP_LW, 5'd0, 5'd20, 16'h0004));
        emit(enc_r(FN_ADDU, 5'd11, 5'd13, 5'd14, 5'd0));
        emit(enc_r(FN_ADDU, 5'd12, 5'd0, 5'd19, 5'd0));
        emit(enc_i(OP_SW, 5'd11, 5'd20, 16'h0000));
        emit(enc_i(OP_LW, 5'd10, 5'd20, 16'h0000));
        emit(enc_i(OP_LW, 5'd9, 5'd20, 16'hfff8));
        add_section("load");
        b = asm_pc;
        emit(enc_i(OP_ORI, 5'd21, 5'd0, 16'h0055));
        emit(enc_i(OP_ORI, 5'd22, 5'd0, 16'h0055));
        emit(enc_i(OP_ORI, 5'd23, 5'd0, 16'h0066));
        // taken beq skips two
        emit(enc_i(OP_BEQ, 5'd22, 5'd21, 16'd2));
        emit(enc_i(OP_ADDIU, 5'd24, 5'd0, 16'd1));
        emit(enc_i(OP_ADDIU, 5'd24, 5'd0, 16'd2));
        emit(enc_i(OP_BEQ, 5'd23, 5'd21, 16'd1));
        emit(enc_i(OP_ADDIU, 5'd25, 5'd0, 16'd3));
        emit(enc_j(b + 32'd40));
        emit(enc_i(OP_ADDIU, 5'd25, 5'd0, 16'd4));
        v = b + 32'd52;
        emit(enc_i(OP_ORI, 5'd26, 5'd0, v[15:0]));
        emit(enc_r(FN_JR, 5'd0, 5'd26, 5'd0, 5'd0));
        emit(enc_i(OP_ADDIU, 5'd27, 5'd0, 16'd6));
        // countdown loop closed by a backward j
        emit(enc_i(OP_ADDIU, 5'd28, 5'd0, 16'd3));
        emit(enc_i(OP_ADDIU, 5'd28, 5'd28, 16'hffff));
        emit(enc_i(OP_BEQ, 5'd0, 5'd28, 16'd1));
        emit(enc_j(b + 32'd56));
        emit(enc_i(OP_ADDIU, 5'd29, 5'd0, 16'd7));
        add_section("control");
        emit(enc_j(asm_pc));
    endtask

    function automatic retire_t retire_view(retire_t r);
        retire_t v;
        v = r;
        if (!v.reg_write) begin
            v.rd = '0;
            v.wdata = '0;
        end
        return v;
    endfunction

    function automatic string retire_text(retire_t r);
        return $sformatf("pc=%h we=%b rd=%0d wdata=%h taken=%b",
                         r.pc, r.reg_write, r.rd, r.wdata, r.taken);
    endfunction

    function automatic string req_text(dmem_req_t r);
        return $sformatf("write=%b addr=%h wdata=%h", r.write, r.addr, r.wdata);
    endfunction

    task automatic check_retire(string name, retire_t exp, retire_t act);
        retire_t e;
        retire_t a;
        e = retire_view(exp);
        a = retire_view(act);
        if (e !== a) begin
            $display("Mismatch %s retire: expected %s actual %s",
                     name, retire_text(e), retire_text(a));
            test_errors++;
        end
    endtask

    task automatic check_dmem_req(string name, dmem_req_t exp, dmem_req_t act);
        dmem_req_t a;
        a = act;
        // a read carries no write data
        if (!a.write) begin
            a.wdata = '0;
        end
        if (exp !== a) begin
            $display("Mismatch %s dmem_req: expected %s actual %s",
                     name, req_text(exp), req_text(a));
            test_errors++;
        end
    endtask

    task automatic check_flag(string name, string what, logic exp, logic act);
        if (exp !== act) begin
            $display("Mismatch %s %s: expected %b actual %b", name, what, exp, act);
            test_errors++;
        end
    endtask

    task automatic check_word(string name, string what, word_t exp, word_t act);
        if (exp !== act) begin
            $display("Mismatch %s %s: expected %h actual %h", name, what, exp, act);
            test_errors++;
        end
    endtask

    task automatic finish_test(string name);
        if (test_errors == 0) begin
            pass_count++;
            $display("[done] %s: ok", name);
        end else begin
            fail_count++;
            $display("[done] %s: %0d errors", name, test_errors);
        end
        test_errors = 0;
    endtask

    // four-phase slave, random delay on each phase
    task automatic serve_dmem();
        dmem_req_t req;
        int        delay;
        forever begin
            @(posedge sys_clk);
            #2;
            if (dmem_req_valid) begin
                dmem_busy = 1'b1;
                req = dmem_req;
                delay = $urandom_range(5, 0);
                repeat (delay) begin
                    @(posedge sys_clk);
                    #2;
                end
                if (req.write) begin
                    data_mem[req.addr[7:2]] = req.wdata;
                end else begin
                    dmem_rdata = data_mem[req.addr[7:2]];
                end
                dmem_ack = 1'b1;
                do begin
                    @(posedge sys_clk);
                    #2;
                end while (dmem_req_valid);
                delay = $urandom_range(5, 0);
                repeat (delay) begin
                    @(posedge sys_clk);
                    #2;
                end
                dmem_ack = 1'b0;
                dmem_busy = 1'b0;
            end
        end
    endtask

    task automatic check_reset();
        for (int i = 0; i <= 8; i++) begin
            if (i < 8) begin
                @(posedge sys_clk);
                #2;
            end else begin
                rst_n = 1'b1;
            end
            check_flag("reset", "retire_valid", 1'b0, retire_valid);
            check_flag("reset", "dmem_req_valid", 1'b0, dmem_req_valid);
            check_word("reset", "imem_addr", RESET_PC, imem_addr);
        end
        finish_test("reset");
    endtask

    task automatic compare_retires();
        retire_t   exp_ret;
        logic      exp_mem;
        dmem_req_t exp_req;
        logic      prev_req;
        string     name;
        prev_req = 1'b0;
        forever begin
            @(posedge sys_clk);
            #2;
            name = (cur_test < num_tests) ? test_names[cur_test] : "tail";
            if (dmem_req_valid && !prev_req) begin
                if (req_queue.size() != 0) begin
                    $display("Error in %s: second data request before the last one retired", name);
                    test_errors++;
                end
                req_queue.push_back(dmem_req);
            end
            prev_req = dmem_req_valid;
            if (retire_valid) begin
                exp_ret = ref_step(exp_mem, exp_req);
                check_retire(name, exp_ret, retire);
                if (exp_mem && req_queue.size() == 0) begin
                    $display("Error in %s: memory instruction at %h retired with no request",
                             name, exp_ret.pc);
                    test_errors++;
                end else if (exp_mem) begin
                    check_dmem_req(name, exp_req, req_queue.pop_front());
                end else if (req_queue.size() != 0) begin
                    $display("Error in %s: data request from a non-memory instruction", name);
                    test_errors++;
                    req_queue.delete();
                end
                if (exp_mem && dmem_busy) begin
                    $display("Error in %s: retired before the bus handshake finished", name);
                    test_errors++;
                end
                if (cur_test < num_tests && ref_pc == test_ends[cur_test]) begin
                    finish_test(name);
                    cur_test++;
                end
            end
        end
    endtask

    task automatic watchdog(int cycles);
        repeat (cycles) @(posedge sys_clk);
        $display("watchdog: core stopped retiring, nothing finished after %0d cycles", cycles);
        $display("TEST FAIL");
        $finish;
    endtask

    initial begin
        int total;
        void'($urandom(67280));
        rst_n = 1'b0;
        dmem_ack = 1'b0;
        dmem_rdata = '0;
        build_program();
        init_model();
        total = count_steps(test_ends[num_tests - 1]);
        init_model();
        fork
            serve_dmem();
            watchdog(total * 12 + 8 + 4);
        join_none
        check_reset();
        fork
            compare_retires();
        join_none
        wait (cur_test == num_tests);
        $display("summary: %0d tests passed, %0d failed", pass_count, fail_count);
        if (fail_count == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

// File: project.f
hdl/cpu_isa_pkg.sv
hdl/cpu_bus_pkg.sv
hdl/ifetch.sv
hdl/idecoder.sv
hdl/execute.sv
hdl/mmu.sv
hdl/top.sv
tests/tb_top.sv
